// File: Bender.yml
package:
  name: bus_system

sources:
  - bus_pkg.sv
  - arb_pkg.sv
  - bus_access.sv
  - fetch_unit.sv
  - load_store_unit.sv
  - dma_copier.sv
  - memory_slave.sv
  - bus_system.sv
  - target: test
    files:
      - tb_checks.sv
      - tb_bus_system.sv

// File: arb_pkg.sv
package arb_pkg;

	localparam int STATE_WIDTH = 2;

	// Arbiter states, one SERVE state per port
	localparam logic [STATE_WIDTH-1:0] IDLE = 2'd0;
	localparam logic [STATE_WIDTH-1:0] SERVE_FETCH = 2'd1;	// Port A
	localparam logic [STATE_WIDTH-1:0] SERVE_LS = 2'd2;	// Port B
	localparam logic [STATE_WIDTH-1:0] SERVE_DMA = 2'd3;	// Port C

	// Grant order, highest first
	localparam logic [STATE_WIDTH-1:0] PRIO_FIRST_LS = SERVE_LS;
	localparam logic [STATE_WIDTH-1:0] PRIO_SECOND_FETCH = SERVE_FETCH;
	localparam logic [STATE_WIDTH-1:0] PRIO_THIRD_DMA = SERVE_DMA;

endpackage

// File: bus_access.sv
module bus_access #(
	parameter bit REGISTERED = 1'b0
)(
	input  logic i_clock,
	input  logic i_reset,

	// Memory bus
	output logic o_bus_rw,
	output logic o_bus_request,
	input  logic i_bus_ready,
	output logic [bus_pkg::ADDR_WIDTH-1:0] o_bus_address,
	input  logic [bus_pkg::DATA_WIDTH-1:0] i_bus_rdata,
	output logic [bus_pkg::DATA_WIDTH-1:0] o_bus_wdata,

	// Port A, read only
	input  logic i_pa_request,
	output logic o_pa_ready,
	input  logic [bus_pkg::ADDR_WIDTH-1:0] i_pa_address,
	output logic [bus_pkg::DATA_WIDTH-1:0] o_pa_rdata,

	// Port B
	input  logic i_pb_rw,
	input  logic i_pb_request,
	output logic o_pb_ready,
	input  logic [bus_pkg::ADDR_WIDTH-1:0] i_pb_address,
	output logic [bus_pkg::DATA_WIDTH-1:0] o_pb_rdata,
	input  logic [bus_pkg::DATA_WIDTH-1:0] i_pb_wdata,

	// Port C
	input  logic i_pc_rw,
	input  logic i_pc_request,
	output logic o_pc_ready,
	input  logic [bus_pkg::ADDR_WIDTH-1:0] i_pc_address,
	output logic [bus_pkg::DATA_WIDTH-1:0] o_pc_rdata,
	input  logic [bus_pkg::DATA_WIDTH-1:0] i_pc_wdata
);

	logic [arb_pkg::STATE_WIDTH-1:0] state;
	logic [arb_pkg::STATE_WIDTH-1:0] pick;	// Winner among current requests
	logic [arb_pkg::STATE_WIDTH-1:0] sel;	// Port steering the command mux
	logic sel_request;
	logic sel_rw;
	logic [bus_pkg::ADDR_WIDTH-1:0] sel_address;
	logic [bus_pkg::DATA_WIDTH-1:0] sel_wdata;

	always_comb begin
		if (i_pb_request)
			pick = arb_pkg::PRIO_FIRST_LS;
		else if (i_pa_request)
			pick = arb_pkg::PRIO_SECOND_FETCH;
		else if (i_pc_request)
			pick = arb_pkg::PRIO_THIRD_DMA;
		else
			pick = arb_pkg::IDLE;
	end

	assign sel = (state == arb_pkg::IDLE) ? pick : state;

	always_comb begin
		sel_request = 1'b0;
		sel_rw = 1'b0;
		sel_address = '0;
		sel_wdata = '0;
		case (sel)
			arb_pkg::SERVE_FETCH: begin
				sel_request = i_pa_request;
				sel_address = i_pa_address;
			end
			arb_pkg::SERVE_LS: begin
				sel_request = i_pb_request;
				sel_rw = i_pb_rw;
				sel_address = i_pb_address;
				sel_wdata = i_pb_wdata;
			end
			arb_pkg::SERVE_DMA: begin
				sel_request = i_pc_request;
				sel_rw = i_pc_rw;
				sel_address = i_pc_address;
				sel_wdata = i_pc_wdata;
			end
			default: ;
		endcase
	end

	// Ready only to the port being served
	assign o_pa_ready = i_pa_request && (state == arb_pkg::SERVE_FETCH) && i_bus_ready;
	assign o_pb_ready = i_pb_request && (state == arb_pkg::SERVE_LS) && i_bus_ready;
	assign o_pc_ready = i_pc_request && (state == arb_pkg::SERVE_DMA) && i_bus_ready;

	assign o_pa_rdata = i_bus_rdata;
	assign o_pb_rdata = i_bus_rdata;
	assign o_pc_rdata = i_bus_rdata;

	if (!REGISTERED) begin : g_comb
		logic [arb_pkg::STATE_WIDTH-1:0] next_state;

		always_comb begin
			if (state == arb_pkg::IDLE)
				next_state = pick;
			else if (i_bus_ready)
				next_state = arb_pkg::IDLE;
			else
				next_state = state;
		end

		always_ff @(posedge i_clock) begin
			if (i_reset)
				state <= arb_pkg::IDLE;
			else
				state <= next_state;
		end

		// Command is out during the grant, request follows in SERVE
		assign o_bus_request = (state != arb_pkg::IDLE) && sel_request;
		assign o_bus_rw = sel_rw;
		assign o_bus_address = sel_address;
		assign o_bus_wdata = sel_wdata;
	end else begin : g_reg
		always_ff @(posedge i_clock) begin
			if (i_reset) begin
				state <= arb_pkg::IDLE;
				o_bus_request <= 1'b0;
			end else if (state == arb_pkg::IDLE) begin
				state <= pick;
				o_bus_request <= sel_request;
			end else if (i_bus_ready) begin
				state <= arb_pkg::IDLE;
				o_bus_request <= 1'b0;
			end
		end

		always_ff @(posedge i_clock) begin
			if (state == arb_pkg::IDLE) begin	// Held through SERVE
				o_bus_rw <= sel_rw;
				o_bus_address <= sel_address;
				o_bus_wdata <= sel_wdata;
			end
		end
	end

endmodule

// File: bus_pkg.sv
package bus_pkg;

	// Bus word sizes
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	// Byte address to word index
	localparam int WORD_BYTES = DATA_WIDTH / 8;
	localparam int BYTE_OFFSET_BITS = $clog2(WORD_BYTES);

	// RAM size, addresses wrap modulo this
	localparam int RAM_WORDS = 256;
	localparam int RAM_INDEX_WIDTH = $clog2(RAM_WORDS);

	// DMA word count
	localparam int COUNT_WIDTH = 8;

endpackage

// File: bus_system.sv
module bus_system #(
	parameter bit REGISTERED = 1'b1,
	parameter int WAIT_STATES = 2
)(
	input  logic i_clock,
	input  logic i_reset,

	// Fetch
	input  logic i_fetch_start,
	input  logic [bus_pkg::ADDR_WIDTH-1:0] i_fetch_address,
	output logic o_fetch_valid,
	output logic [bus_pkg::DATA_WIDTH-1:0] o_fetch_word,
	output logic o_fetch_busy,

	// Load/store
	input  logic i_ls_start,
	input  logic i_ls_write,
	input  logic [bus_pkg::ADDR_WIDTH-1:0] i_ls_address,
	input  logic [bus_pkg::DATA_WIDTH-1:0] i_ls_wdata,
	output logic o_ls_done,
	output logic [bus_pkg::DATA_WIDTH-1:0] o_ls_rdata,
	output logic o_ls_busy,

	// DMA
	input  logic i_dma_start,
	input  logic [bus_pkg::ADDR_WIDTH-1:0] i_dma_src,
	input  logic [bus_pkg::ADDR_WIDTH-1:0] i_dma_dst,
	input  logic [bus_pkg::COUNT_WIDTH-1:0] i_dma_count,
	output logic o_dma_done,
	output logic o_dma_busy
);

	logic fetch_request, fetch_ready;
	logic [bus_pkg::ADDR_WIDTH-1:0] fetch_address;
	logic [bus_pkg::DATA_WIDTH-1:0] fetch_rdata;

	logic ls_request, ls_rw, ls_ready;
	logic [bus_pkg::ADDR_WIDTH-1:0] ls_address;
	logic [bus_pkg::DATA_WIDTH-1:0] ls_wdata, ls_rdata;

	logic dma_request, dma_rw, dma_ready;
	logic [bus_pkg::ADDR_WIDTH-1:0] dma_address;
	logic [bus_pkg::DATA_WIDTH-1:0] dma_wdata, dma_rdata;

	logic bus_request, bus_rw, bus_ready;
	logic [bus_pkg::ADDR_WIDTH-1:0] bus_address;
	logic [bus_pkg::DATA_WIDTH-1:0] bus_wdata, bus_rdata;

	fetch_unit u_fetch (	// Port A
		.i_clock, .i_reset,
		.i_start(i_fetch_start), .i_address(i_fetch_address),
		.o_request(fetch_request), .o_address(fetch_address),
		.i_ready(fetch_ready), .i_rdata(fetch_rdata),
		.o_valid(o_fetch_valid), .o_word(o_fetch_word), .o_busy(o_fetch_busy)
	);

	load_store_unit u_ls (	// Port B
		.i_clock, .i_reset,
		.i_start(i_ls_start), .i_write(i_ls_write),
		.i_address(i_ls_address), .i_wdata(i_ls_wdata),
		.o_request(ls_request), .o_rw(ls_rw), .o_address(ls_address), .o_wdata(ls_wdata),
		.i_ready(ls_ready), .i_rdata(ls_rdata),
		.o_done(o_ls_done), .o_rdata(o_ls_rdata), .o_busy(o_ls_busy)
	);

	dma_copier u_dma (	// Port C
		.i_clock, .i_reset,
		.i_start(i_dma_start), .i_src(i_dma_src), .i_dst(i_dma_dst), .i_count(i_dma_count),
		.o_request(dma_request), .o_rw(dma_rw), .o_address(dma_address), .o_wdata(dma_wdata),
		.i_ready(dma_ready), .i_rdata(dma_rdata),
		.o_done(o_dma_done), .o_busy(o_dma_busy)
	);

	bus_access #(.REGISTERED(REGISTERED)) u_arb (
		.i_clock, .i_reset,
		.o_bus_rw(bus_rw), .o_bus_request(bus_request), .i_bus_ready(bus_ready),
		.o_bus_address(bus_address), .i_bus_rdata(bus_rdata), .o_bus_wdata(bus_wdata),
		.i_pa_request(fetch_request), .o_pa_ready(fetch_ready),
		.i_pa_address(fetch_address), .o_pa_rdata(fetch_rdata),
		.i_pb_rw(ls_rw), .i_pb_request(ls_request), .o_pb_ready(ls_ready),
		.i_pb_address(ls_address), .o_pb_rdata(ls_rdata), .i_pb_wdata(ls_wdata),
		.i_pc_rw(dma_rw), .i_pc_request(dma_request), .o_pc_ready(dma_ready),
		.i_pc_address(dma_address), .o_pc_rdata(dma_rdata), .i_pc_wdata(dma_wdata)
	);

	memory_slave #(.WAIT_STATES(WAIT_STATES)) u_ram (
		.i_clock, .i_reset,
		.i_request(bus_request), .i_rw(bus_rw),
		.i_address(bus_address), .i_wdata(bus_wdata),
		.o_ready(bus_ready), .o_rdata(bus_rdata)
	);

endmodule

// File: dma_copier.sv
module dma_copier (
	input  logic i_clock,
	input  logic i_reset,

	// Command
	input  logic i_start,
	input  logic [bus_pkg::ADDR_WIDTH-1:0] i_src,
	input  logic [bus_pkg::ADDR_WIDTH-1:0] i_dst,
	input  logic [bus_pkg::COUNT_WIDTH-1:0] i_count,

	// Arbiter port
	output logic o_request,
	output logic o_rw,
	output logic [bus_pkg::ADDR_WIDTH-1:0] o_address,
	output logic [bus_pkg::DATA_WIDTH-1:0] o_wdata,
	input  logic i_ready,
	input  logic [bus_pkg::DATA_WIDTH-1:0] i_rdata,

	// Status
	output logic o_done,
	output logic o_busy
);

	logic writing;	// Write half of the current word
	logic [bus_pkg::ADDR_WIDTH-1:0] src_ptr;
	logic [bus_pkg::ADDR_WIDTH-1:0] dst_ptr;
	logic [bus_pkg::COUNT_WIDTH-1:0] remaining;
	logic [bus_pkg::DATA_WIDTH-1:0] hold;

	assign o_request = o_busy;
	assign o_rw = writing;
	assign o_address = writing ? dst_ptr : src_ptr;
	assign o_wdata = hold;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_busy <= 1'b0;
			o_done <= 1'b0;
			writing <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (!o_busy) begin
				writing <= 1'b0;
				if (i_start) begin
					o_busy <= (i_count != '0);
					o_done <= (i_count == '0);	// Empty copy
				end
			end else if (i_ready) begin
				writing <= !writing;
				if (writing && remaining == bus_pkg::COUNT_WIDTH'(1)) begin
					o_busy <= 1'b0;
					o_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (!o_busy && i_start) begin
			src_ptr <= i_src;
			dst_ptr <= i_dst;
			remaining <= i_count;
		end else if (o_busy && i_ready) begin
			if (writing) begin
				dst_ptr <= dst_ptr + bus_pkg::ADDR_WIDTH'(bus_pkg::WORD_BYTES);
				remaining <= remaining - 1'b1;
			end else begin
				hold <= i_rdata;
				src_ptr <= src_ptr + bus_pkg::ADDR_WIDTH'(bus_pkg::WORD_BYTES);
			end
		end
	end

endmodule

// File: fetch_unit.sv
module fetch_unit (
	input  logic i_clock,
	input  logic i_reset,

	// Command
	input  logic i_start,
	input  logic [bus_pkg::ADDR_WIDTH-1:0] i_address,

	// Arbiter port
	output logic o_request,
	output logic [bus_pkg::ADDR_WIDTH-1:0] o_address,
	input  logic i_ready,
	input  logic [bus_pkg::DATA_WIDTH-1:0] i_rdata,

	// Result
	output logic o_valid,
	output logic [bus_pkg::DATA_WIDTH-1:0] o_word,
	output logic o_busy
);

	assign o_request = o_busy;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_busy <= 1'b0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= 1'b0;
			if (!o_busy) begin
				o_busy <= i_start;	// Start while busy is lost
			end else if (i_ready) begin
				o_busy <= 1'b0;
				o_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (!o_busy && i_start)
			o_address <= i_address;
		if (o_busy && i_ready)
			o_word <= i_rdata;
	end

endmodule

// File: files.f
bus_pkg.sv
arb_pkg.sv
bus_access.sv
fetch_unit.sv
load_store_unit.sv
dma_copier.sv
memory_slave.sv
bus_system.sv
tb_checks.sv
tb_bus_system.sv

// File: load_store_unit.sv
module load_store_unit (
	input  logic i_clock,
	input  logic i_reset,

	// Command
	input  logic i_start,
	input  logic i_write,
	input  logic [bus_pkg::ADDR_WIDTH-1:0] i_address,
	input  logic [bus_pkg::DATA_WIDTH-1:0] i_wdata,

	// Arbiter port
	output logic o_request,
	output logic o_rw,
	output logic [bus_pkg::ADDR_WIDTH-1:0] o_address,
	output logic [bus_pkg::DATA_WIDTH-1:0] o_wdata,
	input  logic i_ready,
	input  logic [bus_pkg::DATA_WIDTH-1:0] i_rdata,

	// Result
	output logic o_done,
	output logic [bus_pkg::DATA_WIDTH-1:0] o_rdata,
	output logic o_busy
);

	assign o_request = o_busy;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_busy <= 1'b0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (!o_busy) begin
				o_busy <= i_start;
			end else if (i_ready) begin
				o_busy <= 1'b0;
				o_done <= 1'b1;
			end
		end
	end

	// Command latch, stable for the whole transfer
	always_ff @(posedge i_clock) begin
		if (!o_busy && i_start) begin
			o_rw <= i_write;
			o_address <= i_address;
			o_wdata <= i_wdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (o_busy && i_ready && !o_rw)
			o_rdata <= i_rdata;	// Held after writes
	end

endmodule

// File: memory_slave.sv
module memory_slave #(
	parameter int WAIT_STATES = 2
)(
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_request,
	input  logic i_rw,
	input  logic [bus_pkg::ADDR_WIDTH-1:0] i_address,
	input  logic [bus_pkg::DATA_WIDTH-1:0] i_wdata,
	output logic o_ready,
	output logic [bus_pkg::DATA_WIDTH-1:0] o_rdata
);

	localparam int WAIT_WIDTH = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

	logic [bus_pkg::DATA_WIDTH-1:0] mem [bus_pkg::RAM_WORDS];
	logic [WAIT_WIDTH-1:0] wait_count;
	logic [bus_pkg::RAM_INDEX_WIDTH-1:0] index;
	logic finish;	// Last wait state, ready follows

	// Word index, upper address bits ignored
	assign index = i_address[bus_pkg::BYTE_OFFSET_BITS +: bus_pkg::RAM_INDEX_WIDTH];
	assign finish = i_request && !o_ready && (wait_count == WAIT_WIDTH'(WAIT_STATES));

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wait_count <= '0;
			o_ready <= 1'b0;
		end else begin
			o_ready <= finish;
			if (finish)
				wait_count <= '0;
			else if (i_request && !o_ready)
				wait_count <= wait_count + 1'b1;
		end
	end

	// Access lands on the edge that raises ready
	always_ff @(posedge i_clock) begin
		if (finish) begin
			if (i_rw)
				mem[index] <= i_wdata;
			else
				o_rdata <= mem[index];
		end
	end

endmodule

// File: tb_bus_system.sv
module tb_bus_system #(
	parameter bit REGISTERED = 1'b1,
	parameter int WAIT_STATES = 2
);

	localparam int WORD_BYTES = bus_pkg::DATA_WIDTH / 8;
	localparam int TRANSFER_CYCLES = 2 * (WAIT_STATES + 3);
	localparam int TIMEOUT_CYCLES = 300 * TRANSFER_CYCLES;	// About 300 transfers in all tests

	logic clock, reset;
	logic fetch_start, fetch_valid, fetch_busy;
	logic [31:0] fetch_address, fetch_word;
	logic ls_start, ls_write, ls_done, ls_busy;
	logic [31:0] ls_address, ls_wdata, ls_rdata;
	logic dma_start, dma_done, dma_busy;
	logic [31:0] dma_src, dma_dst;
	logic [bus_pkg::COUNT_WIDTH-1:0] dma_count;
	int failures;
	int cycle_count = 0;
	int fetch_starts = 0, fetch_ends = 0, ls_starts = 0, ls_ends = 0, dma_starts = 0, dma_ends = 0;
	logic [31:0] seed = 32'd28;
	logic [31:0] ref_mem [bus_pkg::RAM_WORDS];
	logic [31:0] written [16];

	bus_system #(.REGISTERED(REGISTERED), .WAIT_STATES(WAIT_STATES)) dut (
		.i_clock(clock), .i_reset(reset),
		.i_fetch_start(fetch_start), .i_fetch_address(fetch_address),
		.o_fetch_valid(fetch_valid), .o_fetch_word(fetch_word), .o_fetch_busy(fetch_busy),
		.i_ls_start(ls_start), .i_ls_write(ls_write), .i_ls_address(ls_address),
		.i_ls_wdata(ls_wdata), .o_ls_done(ls_done), .o_ls_rdata(ls_rdata), .o_ls_busy(ls_busy),
		.i_dma_start(dma_start), .i_dma_src(dma_src), .i_dma_dst(dma_dst),
		.i_dma_count(dma_count), .o_dma_done(dma_done), .o_dma_busy(dma_busy)
	);

	tb_checks u_checks (
		.i_clock(clock), .i_reset(reset),
		.i_fetch_start(fetch_start), .i_ls_start(ls_start), .i_dma_start(dma_start),
		.i_fetch_valid(fetch_valid), .i_fetch_busy(fetch_busy), .i_ls_done(ls_done),
		.i_ls_busy(ls_busy), .i_dma_done(dma_done), .i_dma_busy(dma_busy),
		.o_failures(failures)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		fetch_ends += fetch_valid;
		ls_ends += ls_done;
		dma_ends += dma_done;
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	// Word index of a byte address, wrapping at the RAM size
	function automatic int ram_index(input logic [31:0] address);
		return (address / WORD_BYTES) % bus_pkg::RAM_WORDS;
	endfunction

	task automatic step();
		@(posedge clock);
		#1;
	endtask

	task automatic ls_access(input logic write, input logic [31:0] address,
			input logic [31:0] data, output logic [31:0] rdata);
		while (ls_busy)
			step();
		ls_write = write;
		ls_address = address;
		ls_wdata = data;
		ls_start = 1'b1;
		step();
		ls_start = 1'b0;
		ls_starts++;
		while (!ls_done)
			step();
		rdata = ls_rdata;
		if (write)
			ref_mem[ram_index(address)] = data;
	endtask

	task automatic start_fetch(input logic [31:0] address);
		while (fetch_busy)
			step();
		fetch_address = address;
		fetch_start = 1'b1;
		step();
		fetch_start = 1'b0;
		fetch_starts++;
	endtask

	task automatic dma_copy(input bit with_fetch);
		logic [31:0] src, dst, rdata;
		int count;
		bit fetch_seen, dma_seen, fetch_first;
		src = (next_random() % 96) * WORD_BYTES;
		dst = (128 + next_random() % 96) * WORD_BYTES;	// Disjoint from the source
		count = 1 + next_random() % 32;
		if (with_fetch && count < 4)
			count = 4;
		for (int i = 0; i < count; i++)
			ls_access(1'b1, src + i * WORD_BYTES, next_random(), rdata);
		while (dma_busy)
			step();
		dma_src = src;
		dma_dst = dst;
		dma_count = bus_pkg::COUNT_WIDTH'(count);
		dma_start = 1'b1;
		step();
		dma_start = 1'b0;
		dma_starts++;
		fetch_seen = !with_fetch;
		dma_seen = 1'b0;
		fetch_first = 1'b1;
		if (with_fetch) begin
			step();
			start_fetch(src);
		end
		while (!dma_seen || !fetch_seen) begin
			step();
			if (dma_done)
				dma_seen = 1'b1;
			if (fetch_valid) begin
				fetch_seen = 1'b1;
				fetch_first = !dma_seen;
				u_checks.check_value("o_fetch_word", ref_mem[ram_index(src)], fetch_word);
			end
		end
		if (with_fetch)
			u_checks.check_condition(fetch_first, "DMA finished before the fetch started during it");
		for (int i = 0; i < count; i++)	// Forward copy, one word at a time
			ref_mem[ram_index(dst + i * WORD_BYTES)] = ref_mem[ram_index(src + i * WORD_BYTES)];
		for (int i = 0; i < count; i++) begin
			ls_access(1'b0, dst + i * WORD_BYTES, '0, rdata);
			u_checks.check_value("o_ls_rdata", ref_mem[ram_index(dst + i * WORD_BYTES)], rdata);
		end
	endtask

	initial begin
		logic [31:0] data, rdata;
		bit ls_seen, fetch_seen, order_ok;
		reset = 1'b1;
		{fetch_start, ls_start, ls_write, dma_start} = '0;
		{fetch_address, ls_address, ls_wdata, dma_src, dma_dst} = '0;
		dma_count = '0;
		repeat (2)
			step();
		reset = 1'b0;

		u_checks.start_test("reset state");
		repeat (4) begin
			step();
			u_checks.check_value("status flags", '0,
				{fetch_valid, fetch_busy, ls_done, ls_busy, dma_done, dma_busy});
		end
		u_checks.finish_test();

		u_checks.start_test("write then read");
		for (int i = 0; i < 16; i++) begin
			written[i] = next_random();
			data = next_random();
			ls_access(1'b1, written[i], data, rdata);
			ls_access(1'b0, written[i], '0, rdata);
			u_checks.check_value("o_ls_rdata", data, rdata);
		end
		u_checks.finish_test();

		u_checks.start_test("fetch");
		start_fetch(written[3]);
		while (!fetch_valid)
			step();
		u_checks.check_value("o_fetch_word", ref_mem[ram_index(written[3])], fetch_word);
		u_checks.finish_test();

		u_checks.start_test("dma copy");
		dma_copy(1'b0);
		u_checks.finish_test();

		u_checks.start_test("priority");
		fetch_address = written[0];
		ls_address = written[1];
		ls_write = 1'b0;
		fetch_start = 1'b1;
		ls_start = 1'b1;
		step();
		fetch_start = 1'b0;
		ls_start = 1'b0;
		fetch_starts++;
		ls_starts++;
		ls_seen = 1'b0;
		fetch_seen = 1'b0;
		order_ok = 1'b1;
		while (!ls_seen || !fetch_seen) begin
			step();
			if (ls_done) begin
				ls_seen = 1'b1;
				u_checks.check_value("o_ls_rdata", ref_mem[ram_index(written[1])], ls_rdata);
			end
			if (fetch_valid) begin
				fetch_seen = 1'b1;
				order_ok = ls_seen;
				u_checks.check_value("o_fetch_word", ref_mem[ram_index(written[0])], fetch_word);
			end
		end
		u_checks.check_condition(order_ok, "fetch finished before the load/store started with it");
		u_checks.finish_test();

		u_checks.start_test("sharing");
		dma_copy(1'b1);
		step();
		u_checks.check_value("fetch completions", fetch_starts, fetch_ends);
		u_checks.check_value("load/store completions", ls_starts, ls_ends);
		u_checks.check_value("DMA completions", dma_starts, dma_ends);
		u_checks.finish_test();

		u_checks.report();
		if (failures == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: tb_checks.sv
module tb_checks (
	input  logic i_clock,
	input  logic i_reset,
	input  logic i_fetch_start,
	input  logic i_ls_start,
	input  logic i_dma_start,
	input  logic i_fetch_valid,
	input  logic i_fetch_busy,
	input  logic i_ls_done,
	input  logic i_ls_busy,
	input  logic i_dma_done,
	input  logic i_dma_busy,
	output int o_failures
);

	int failures = 0;
	int checks = 0;
	int test_number = 0;
	int test_failures = 0;
	int tests_failed = 0;
	string test_name;

	assign o_failures = failures;

	task automatic count_failure();
		failures++;
		test_failures++;
	endtask

	task automatic start_test(input string name);
		test_number++;
		test_name = name;
		test_failures = 0;
	endtask

	task automatic finish_test();
		if (test_failures != 0)
			tests_failed++;
		$display("Test %0d %s: %s, %0d failures", test_number, test_name,
			(test_failures == 0) ? "ok" : "bad", test_failures);
	endtask

	task automatic check_value(input string name, input logic [bus_pkg::DATA_WIDTH-1:0] expected,
			input logic [bus_pkg::DATA_WIDTH-1:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			$display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			count_failure();
		end
	endtask

	task automatic check_condition(input bit ok, input string what);
		checks++;
		assert (ok)
		else begin
			$display("Error at %0t: %s", $time, what);
			count_failure();
		end
	endtask

	task automatic report();
		$display("Summary: %0d of %0d tests clean, %0d checks, %0d failures",
			test_number - tests_failed, test_number, checks, failures);
	endtask

	// Synchronous reset clears strobes and busy flags on the next edge
	assert property (@(posedge i_clock) i_reset |=> !(i_fetch_valid || i_fetch_busy
			|| i_ls_done || i_ls_busy || i_dma_done || i_dma_busy))
	else begin
		$display("Error at %0t: a strobe or busy flag is high after reset", $time);
		count_failure();
	end

	// Each completion strobe closes a busy period, so it lasts one cycle
	// An empty DMA copy has no busy period, its done follows the start
	assert property (@(posedge i_clock) disable iff (i_reset)
			(!i_fetch_valid || (!i_fetch_busy && $past(i_fetch_busy)))
			&& (!i_ls_done || (!i_ls_busy && $past(i_ls_busy)))
			&& (!i_dma_done || (!i_dma_busy && ($past(i_dma_busy) || $past(i_dma_start)))))
	else begin
		$display("Error at %0t: a completion strobe came without a busy period", $time);
		count_failure();
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
			(!$rose(i_fetch_busy) || $past(i_fetch_start))
			&& (!$rose(i_ls_busy) || $past(i_ls_start))
			&& (!$rose(i_dma_busy) || $past(i_dma_start)))
	else begin
		$display("Error at %0t: a unit went busy without a start strobe", $time);
		count_failure();
	end

endmodule
